//--- hw/axi_xbar_pkg.sv
package axi_xbar_pkg;

  // Interconnect dimensions
  localparam int NUM_MANAGERS = 3;
  localparam int NUM_SUBS = 2;

  // Manager index carried by the arbiter and the grant FIFO
  typedef logic [1:0] grant_t;

  // No manager holds the grant
  localparam grant_t GRANT_IDLE = 2'd3;

  // AXI read response code
  typedef logic [1:0] resp_t;

  // Grant FIFO holds 2**FIFO_ADDR_BITS indices, one per read in flight
  localparam int FIFO_ADDR_BITS = 3;

endpackage

//--- hw/grant_arbiter.sv
`timescale 1ns/1ps

module grant_arbiter (
  input  logic                                      axi_clk,
  input  logic                                      axi_resetn,
  input  logic [axi_xbar_pkg::NUM_MANAGERS-1:0]     request_mask,
  input  logic                                      txn_accepted,
  input  logic                                      fifo_full,
  output axi_xbar_pkg::grant_t                      active_grant
);

  logic [axi_xbar_pkg::NUM_MANAGERS-1:0] holder_mask;
  logic [axi_xbar_pkg::NUM_MANAGERS-1:0] masked_req;
  logic                                  holder_req;
  axi_xbar_pkg::grant_t                  lowest_req;
  axi_xbar_pkg::grant_t                  next_grant;

  // Current holder and whether it still asks for this subordinate
  always_comb begin
    holder_mask = '0;
    holder_req  = 1'b0;
    if (active_grant != axi_xbar_pkg::GRANT_IDLE) begin
      holder_mask[active_grant] = 1'b1;
      holder_req                = request_mask[active_grant];
    end
  end

  // Others first, so the holder gives way to anyone waiting
  assign masked_req = request_mask & ~holder_mask;

  // Lowest index wins among the remaining requesters
  always_comb begin
    lowest_req = axi_xbar_pkg::GRANT_IDLE;
    for (int n = axi_xbar_pkg::NUM_MANAGERS - 1; n >= 0; n--) begin
      if (masked_req[n]) begin
        lowest_req = axi_xbar_pkg::grant_t'(n);
      end
    end
  end

  // A holder that no longer requests counts as idle, so a kept grant
  // cannot lock out the other managers
  always_comb begin
    next_grant = active_grant;
    if (!holder_req || txn_accepted) begin
      if (fifo_full) begin
        next_grant = axi_xbar_pkg::GRANT_IDLE;
      end else if (|masked_req) begin
        next_grant = lowest_req;
      end else if (holder_req) begin
        // Nobody else waiting, keep the holder and skip a bubble
        next_grant = active_grant;
      end else begin
        next_grant = axi_xbar_pkg::GRANT_IDLE;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      active_grant <= axi_xbar_pkg::GRANT_IDLE;
    end else begin
      active_grant <= next_grant;
    end
  end

endmodule

//--- hw/grant_fifo.sv
`timescale 1ns/1ps

module grant_fifo (
  input  logic                 axi_clk,
  input  logic                 axi_resetn,
  input  logic                 push,
  input  axi_xbar_pkg::grant_t push_data,
  input  logic                 pop,
  output axi_xbar_pkg::grant_t head,
  output logic                 empty,
  output logic                 full
);

  localparam int AW = axi_xbar_pkg::FIFO_ADDR_BITS;
  localparam int DEPTH = 1 << AW;

  axi_xbar_pkg::grant_t mem [DEPTH];

  // Extra top bit tells a full buffer from an empty one
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        push_ok;
  logic        pop_ok;

  assign empty   = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  // Oldest accepted grant, valid while not empty
  assign head = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge axi_clk) begin
    if (push_ok) begin
      mem[wr_ptr[AW-1:0]] <= push_data;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

//--- hw/rd_sub_port.sv
`timescale 1ns/1ps

module rd_sub_port #(
  parameter int SUB_INDEX,
  parameter int ADDR_WIDTH,
  parameter int DATA_WIDTH
) (
  input  logic                                                         axi_clk,
  input  logic                                                         axi_resetn,

  // All managers, packed by manager index
  input  logic [axi_xbar_pkg::NUM_MANAGERS-1:0][ADDR_WIDTH-1:0]        mgr_araddr,
  input  logic [axi_xbar_pkg::NUM_MANAGERS-1:0]                        mgr_arvalid,
  input  logic [axi_xbar_pkg::NUM_MANAGERS-1:0]                        mgr_rready,
  output logic [axi_xbar_pkg::NUM_MANAGERS-1:0]                        mgr_arready,
  output logic [axi_xbar_pkg::NUM_MANAGERS-1:0]                        mgr_rvalid,
  output logic [axi_xbar_pkg::NUM_MANAGERS-1:0][DATA_WIDTH-1:0]        mgr_rdata,
  output axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_MANAGERS-1:0]         mgr_rresp,

  // Subordinate read channels
  output logic [ADDR_WIDTH-1:0]                                        sub_araddr,
  output logic                                                         sub_arvalid,
  input  logic                                                         sub_arready,
  input  logic                                                         sub_rvalid,
  input  logic [DATA_WIDTH-1:0]                                        sub_rdata,
  input  axi_xbar_pkg::resp_t                                          sub_rresp,
  output logic                                                         sub_rready
);

  logic [axi_xbar_pkg::NUM_MANAGERS-1:0] request_mask;
  axi_xbar_pkg::grant_t                  active_grant;
  axi_xbar_pkg::grant_t                  fifo_head;
  logic                                  fifo_empty;
  logic                                  fifo_full;
  logic                                  txn_accepted;
  logic                                  txn_completed;

  // A manager requests this port when its address parity matches
  always_comb begin
    for (int n = 0; n < axi_xbar_pkg::NUM_MANAGERS; n++) begin
      request_mask[n] = mgr_arvalid[n] && (mgr_araddr[n][0] == 1'(SUB_INDEX));
    end
  end

  grant_arbiter arbiter_i (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .request_mask (request_mask),
    .txn_accepted (txn_accepted),
    .fifo_full    (fifo_full),
    .active_grant (active_grant)
  );

  // AR side follows the request grant
  // Valid is held back while every response slot is taken
  always_comb begin
    sub_araddr  = '0;
    sub_arvalid = 1'b0;
    mgr_arready = '0;
    if (active_grant != axi_xbar_pkg::GRANT_IDLE) begin
      sub_araddr                = mgr_araddr[active_grant];
      sub_arvalid               = request_mask[active_grant] && !fifo_full;
      mgr_arready[active_grant] = sub_arvalid && sub_arready;
    end
  end

  assign txn_accepted  = sub_arvalid && sub_arready;
  assign txn_completed = sub_rvalid && sub_rready;

  // Accept order of granted managers, consumed by the R side
  grant_fifo resp_fifo_i (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .push       (txn_accepted),
    .push_data  (active_grant),
    .pop        (txn_completed),
    .head       (fifo_head),
    .empty      (fifo_empty),
    .full       (fifo_full)
  );

  // R side goes to the manager at the FIFO head
  always_comb begin
    mgr_rvalid = '0;
    mgr_rdata  = '0;
    mgr_rresp  = '0;
    sub_rready = 1'b0;
    if (!fifo_empty) begin
      mgr_rvalid[fifo_head] = sub_rvalid;
      mgr_rdata[fifo_head]  = sub_rdata;
      mgr_rresp[fifo_head]  = sub_rresp;
      sub_rready            = mgr_rready[fifo_head];
    end
  end

endmodule

//--- hw/axi_rd_3to2.sv
`timescale 1ns/1ps

module axi_rd_3to2 #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16
) (
  input  logic                      axi_clk,
  input  logic                      axi_resetn,

  // Manager 0
  input  logic [ADDR_WIDTH-1:0]     m0_araddr,
  input  logic                      m0_arvalid,
  output logic                      m0_arready,
  output logic                      m0_rvalid,
  output logic [DATA_WIDTH-1:0]     m0_rdata,
  output axi_xbar_pkg::resp_t       m0_rresp,
  input  logic                      m0_rready,

  // Manager 1
  input  logic [ADDR_WIDTH-1:0]     m1_araddr,
  input  logic                      m1_arvalid,
  output logic                      m1_arready,
  output logic                      m1_rvalid,
  output logic [DATA_WIDTH-1:0]     m1_rdata,
  output axi_xbar_pkg::resp_t       m1_rresp,
  input  logic                      m1_rready,

  // Manager 2
  input  logic [ADDR_WIDTH-1:0]     m2_araddr,
  input  logic                      m2_arvalid,
  output logic                      m2_arready,
  output logic                      m2_rvalid,
  output logic [DATA_WIDTH-1:0]     m2_rdata,
  output axi_xbar_pkg::resp_t       m2_rresp,
  input  logic                      m2_rready,

  // Subordinate 0, even addresses
  output logic [ADDR_WIDTH-1:0]     s0_araddr,
  output logic                      s0_arvalid,
  input  logic                      s0_arready,
  input  logic                      s0_rvalid,
  input  logic [DATA_WIDTH-1:0]     s0_rdata,
  input  axi_xbar_pkg::resp_t       s0_rresp,
  output logic                      s0_rready,

  // Subordinate 1, odd addresses
  output logic [ADDR_WIDTH-1:0]     s1_araddr,
  output logic                      s1_arvalid,
  input  logic                      s1_arready,
  input  logic                      s1_rvalid,
  input  logic [DATA_WIDTH-1:0]     s1_rdata,
  input  axi_xbar_pkg::resp_t       s1_rresp,
  output logic                      s1_rready
);

  localparam int NM = axi_xbar_pkg::NUM_MANAGERS;
  localparam int NS = axi_xbar_pkg::NUM_SUBS;

  // Manager inputs packed by index
  logic [NM-1:0][ADDR_WIDTH-1:0] mgr_araddr;
  logic [NM-1:0]                 mgr_arvalid;
  logic [NM-1:0]                 mgr_rready;
  logic [NM-1:0]                 sub1_rready_in;

  // Per-port outputs toward the managers
  logic [NS-1:0][NM-1:0]                 port_arready;
  logic [NS-1:0][NM-1:0]                 port_rvalid;
  logic [NS-1:0][NM-1:0][DATA_WIDTH-1:0] port_rdata;
  axi_xbar_pkg::resp_t [NS-1:0][NM-1:0]  port_rresp;

  // Merged per manager
  logic [NM-1:0]                 mgr_arready;
  logic [NM-1:0]                 mgr_rvalid;
  logic [NM-1:0][DATA_WIDTH-1:0] mgr_rdata;
  axi_xbar_pkg::resp_t [NM-1:0]  mgr_rresp;

  assign mgr_araddr  = {m2_araddr, m1_araddr, m0_araddr};
  assign mgr_arvalid = {m2_arvalid, m1_arvalid, m0_arvalid};
  assign mgr_rready  = {m2_rready, m1_rready, m0_rready};

  // Both ports may answer the same manager at once
  // Port 0 goes first, port 1 waits with its response held
  assign sub1_rready_in = mgr_rready & ~port_rvalid[0];

  rd_sub_port #(
    .SUB_INDEX  (0),
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) sub0_port_i (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .mgr_araddr  (mgr_araddr),
    .mgr_arvalid (mgr_arvalid),
    .mgr_rready  (mgr_rready),
    .mgr_arready (port_arready[0]),
    .mgr_rvalid  (port_rvalid[0]),
    .mgr_rdata   (port_rdata[0]),
    .mgr_rresp   (port_rresp[0]),
    .sub_araddr  (s0_araddr),
    .sub_arvalid (s0_arvalid),
    .sub_arready (s0_arready),
    .sub_rvalid  (s0_rvalid),
    .sub_rdata   (s0_rdata),
    .sub_rresp   (s0_rresp),
    .sub_rready  (s0_rready)
  );

  rd_sub_port #(
    .SUB_INDEX  (1),
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) sub1_port_i (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .mgr_araddr  (mgr_araddr),
    .mgr_arvalid (mgr_arvalid),
    .mgr_rready  (sub1_rready_in),
    .mgr_arready (port_arready[1]),
    .mgr_rvalid  (port_rvalid[1]),
    .mgr_rdata   (port_rdata[1]),
    .mgr_rresp   (port_rresp[1]),
    .sub_araddr  (s1_araddr),
    .sub_arvalid (s1_arvalid),
    .sub_arready (s1_arready),
    .sub_rvalid  (s1_rvalid),
    .sub_rdata   (s1_rdata),
    .sub_rresp   (s1_rresp),
    .sub_rready  (s1_rready)
  );

  // Each port drives zeros to managers it is not serving
  always_comb begin
    for (int n = 0; n < NM; n++) begin
      mgr_arready[n] = port_arready[0][n] | port_arready[1][n];
      mgr_rvalid[n]  = port_rvalid[0][n] | port_rvalid[1][n];
      mgr_rdata[n]   = port_rvalid[0][n] ? port_rdata[0][n] : port_rdata[1][n];
      mgr_rresp[n]   = port_rvalid[0][n] ? port_rresp[0][n] : port_rresp[1][n];
    end
  end

  assign m0_arready = mgr_arready[0];
  assign m0_rvalid  = mgr_rvalid[0];
  assign m0_rdata   = mgr_rdata[0];
  assign m0_rresp   = mgr_rresp[0];

  assign m1_arready = mgr_arready[1];
  assign m1_rvalid  = mgr_rvalid[1];
  assign m1_rdata   = mgr_rdata[1];
  assign m1_rresp   = mgr_rresp[1];

  assign m2_arready = mgr_arready[2];
  assign m2_rvalid  = mgr_rvalid[2];
  assign m2_rdata   = mgr_rdata[2];
  assign m2_rresp   = mgr_rresp[2];

endmodule

//--- include/tb_rd_model.svh
`ifndef TB_RD_MODEL_SVH
`define TB_RD_MODEL_SVH

// Galois LFSR state, stepped once for every random bit taken
logic [15:0] lfsr_state = 16'd98;

function automatic logic [31:0] rand_bits(input int width);
  logic [31:0] value;
  logic        lsb;
  value = '0;
  for (int i = 0; i < width; i++) begin
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    value = {value[30:0], lsb};
  end
  return value;
endfunction

// Each subordinate scrambles its data with its own constant
localparam logic [DW-1:0] SUB_XOR [2] = '{16'h5A5A, 16'hC33C};

function automatic logic [DW-1:0] expected_rdata(input logic [AW-1:0] addr, input int sub);
  return addr[DW-1:0] ^ SUB_XOR[sub];
endfunction

// Expected reads, indexed by manager * 2 + subordinate, oldest first
logic [AW-1:0] exp_q [6][$];

// Addresses accepted by each subordinate model, answered in order
logic [AW-1:0] sub_q [2][$];

// Reads in flight per subordinate and the highest count seen
int sub_out [2];
int max_out [2];

`endif

//--- test/tb_axi_rd_3to2.sv
`timescale 1ns/1ps

module tb_axi_rd_3to2;

  localparam int AW = 20;
  localparam int DW = 16;
  localparam int N_RAND = 40;
  localparam int N_STRESS = 16;
  localparam int TOTAL_READS = 3 * N_RAND + 3 * N_STRESS + 6;

  logic          axi_clk;
  logic          axi_resetn;
  logic [AW-1:0] m_araddr [3];
  logic          m_arvalid [3];
  logic          m_arready [3];
  logic          m_rvalid [3];
  logic [DW-1:0] m_rdata [3];
  logic [1:0]    m_rresp [3];
  logic          m_rready [3];
  logic [AW-1:0] s_araddr [2];
  logic          s_arvalid [2];
  logic          s_arready [2];
  logic          s_rvalid [2];
  logic [DW-1:0] s_rdata [2];
  logic [1:0]    s_rresp [2];
  logic          s_rready [2];

  `include "tb_rd_model.svh"

  int            err_count;
  int            test_errors;
  int            tests_run;
  string         cur_test;
  int            budget [3];
  bit            stress;
  bit            load_req [3];
  logic [AW-1:0] load_addr [3];
  bit            ar_done [3];
  bit            r_done [2];
  int            wait_cnt [2];
  bit            prio_arm [2];
  int            last_mgr [2];
  bit            waited [2][3];
  int            completed;

  axi_rd_3to2 #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) dut_i (
    .axi_clk (axi_clk), .axi_resetn (axi_resetn),
    .m0_araddr (m_araddr[0]), .m0_arvalid (m_arvalid[0]), .m0_arready (m_arready[0]),
    .m0_rvalid (m_rvalid[0]), .m0_rdata (m_rdata[0]), .m0_rresp (m_rresp[0]),
    .m0_rready (m_rready[0]),
    .m1_araddr (m_araddr[1]), .m1_arvalid (m_arvalid[1]), .m1_arready (m_arready[1]),
    .m1_rvalid (m_rvalid[1]), .m1_rdata (m_rdata[1]), .m1_rresp (m_rresp[1]),
    .m1_rready (m_rready[1]),
    .m2_araddr (m_araddr[2]), .m2_arvalid (m_arvalid[2]), .m2_arready (m_arready[2]),
    .m2_rvalid (m_rvalid[2]), .m2_rdata (m_rdata[2]), .m2_rresp (m_rresp[2]),
    .m2_rready (m_rready[2]),
    .s0_araddr (s_araddr[0]), .s0_arvalid (s_arvalid[0]), .s0_arready (s_arready[0]),
    .s0_rvalid (s_rvalid[0]), .s0_rdata (s_rdata[0]), .s0_rresp (s_rresp[0]),
    .s0_rready (s_rready[0]),
    .s1_araddr (s_araddr[1]), .s1_arvalid (s_arvalid[1]), .s1_arready (s_arready[1]),
    .s1_rvalid (s_rvalid[1]), .s1_rdata (s_rdata[1]), .s1_rresp (s_rresp[1]),
    .s1_rready (s_rready[1])
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      err_count++;
      test_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error in test %s: %s", cur_test, msg);
    err_count++;
    test_errors++;
  endtask

  task automatic finish_test();
    $display("Test %s done with %0d errors", cur_test, test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  function automatic bit busy();
    bit b;
    b = (sub_out[0] + sub_out[1]) != 0;
    for (int n = 0; n < 3; n++) begin
      b = b || m_arvalid[n] || load_req[n] || budget[n] > 0;
    end
    return b;
  endfunction

  task automatic wait_drain();
    @(posedge axi_clk);
    while (busy()) begin
      @(posedge axi_clk);
    end
    repeat (3) @(posedge axi_clk);
  endtask

  initial begin
    axi_clk = 1'b0;
    forever #10 axi_clk = ~axi_clk;
  end

  // Handshakes are sampled at the rising edge
  always @(posedge axi_clk) begin
    int            acc;
    bit            found;
    bit            req;
    logic [AW-1:0] a;
    if (axi_resetn) begin
      for (int n = 0; n < 3; n++) begin
        if (m_arvalid[n] && m_arready[n]) begin
          exp_q[n * 2 + m_araddr[n][0]].push_back(m_araddr[n]);
          ar_done[n] = 1'b1;
        end
        if (m_rvalid[n] && m_rready[n]) begin
          if (m_rresp[n] > 1 || exp_q[n * 2 + m_rresp[n]].size() == 0) begin
            report_error($sformatf("manager %0d got a response with no matching read", n));
          end else begin
            a = exp_q[n * 2 + m_rresp[n]].pop_front();
            check_value({cur_test, " rdata"}, expected_rdata(a, m_rresp[n]), m_rdata[n]);
          end
          completed++;
        end
      end
      for (int k = 0; k < 2; k++) begin
        if (s_arvalid[k]) begin
          check_value({cur_test, " address parity"}, k, s_araddr[k][0]);
          found = 1'b0;
          for (int n = 0; n < 3; n++) begin
            found = found || (m_arvalid[n] && m_araddr[n] == s_araddr[k]);
          end
          if (!found) begin
            report_error($sformatf("subordinate %0d address not offered by any manager", k));
          end
          if (prio_arm[k]) begin
            check_value({cur_test, " first grant"}, m_araddr[0], s_araddr[k]);
            prio_arm[k] = 1'b0;
          end
        end
        for (int m = 0; m < 3; m++) begin
          req = m_arvalid[m] && m_araddr[m][0] == k[0];
          waited[k][m] = waited[k][m] && req;
        end
        if (s_arvalid[k] && s_arready[k]) begin
          acc = -1;
          for (int n = 0; n < 3; n++) begin
            if (m_arvalid[n] && m_arready[n] && m_araddr[n][0] == k[0]) begin
              acc = n;
            end
          end
          for (int m = 0; m < 3; m++) begin
            if (acc == last_mgr[k] && m != acc && waited[k][m]) begin
              report_error($sformatf("manager %0d kept sub %0d while manager %0d waited",
                                     acc, k, m));
            end
          end
          last_mgr[k] = acc;
          for (int m = 0; m < 3; m++) begin
            waited[k][m] = m != acc && m_arvalid[m] && m_araddr[m][0] == k[0];
          end
          sub_q[k].push_back(s_araddr[k]);
          sub_out[k]++;
          if (sub_out[k] > max_out[k]) begin
            max_out[k] = sub_out[k];
          end
        end
        if (s_rvalid[k] && s_rready[k]) begin
          void'(sub_q[k].pop_front());
          sub_out[k]--;
          r_done[k] = 1'b1;
        end
      end
    end
  end

  // Manager and subordinate models drive on the falling edge
  always @(negedge axi_clk) begin
    if (axi_resetn) begin
      for (int n = 0; n < 3; n++) begin
        if (ar_done[n]) begin
          m_arvalid[n] = 1'b0;
          ar_done[n] = 1'b0;
        end
        if (!m_arvalid[n]) begin
          if (load_req[n]) begin
            m_araddr[n] = load_addr[n];
            m_arvalid[n] = 1'b1;
            load_req[n] = 1'b0;
          end else if (budget[n] > 0 && (stress || rand_bits(1))) begin
            m_araddr[n] = rand_bits(AW);
            m_arvalid[n] = 1'b1;
            budget[n]--;
          end
        end
        m_rready[n] = stress || rand_bits(2) != 0;
      end
      for (int k = 0; k < 2; k++) begin
        if (r_done[k]) begin
          s_rvalid[k] = 1'b0;
          r_done[k] = 1'b0;
          wait_cnt[k] = stress ? 10 + rand_bits(4) : rand_bits(3);
        end
        if (!s_rvalid[k] && sub_q[k].size() > 0) begin
          if (wait_cnt[k] > 0) begin
            wait_cnt[k]--;
          end else begin
            s_rvalid[k] = 1'b1;
            s_rdata[k] = expected_rdata(sub_q[k][0], k);
            s_rresp[k] = 2'(k);
          end
        end
        s_arready[k] = stress || rand_bits(1);
      end
    end
  end

  initial begin
    #(TOTAL_READS * 200 * 20);
    $display("Timeout: the reads did not all complete in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    logic [AW-1:0] base;
    axi_resetn = 1'b0;
    for (int n = 0; n < 3; n++) begin
      m_araddr[n] = '0;
      m_arvalid[n] = 1'b0;
      m_rready[n] = 1'b0;
    end
    for (int k = 0; k < 2; k++) begin
      s_arready[k] = 1'b0;
      s_rvalid[k] = 1'b0;
      s_rdata[k] = '0;
      s_rresp[k] = '0;
      last_mgr[k] = -1;
    end
    cur_test = "reset";
    repeat (5) @(negedge axi_clk);
    axi_resetn <= 1'b1;
    repeat (3) begin
      @(posedge axi_clk);
      for (int n = 0; n < 3; n++) begin
        check_value("reset arready", 0, m_arready[n]);
        check_value("reset rvalid", 0, m_rvalid[n]);
      end
      check_value("reset s0 arvalid", 0, s_arvalid[0]);
      check_value("reset s1 arvalid", 0, s_arvalid[1]);
    end
    finish_test();

    // Three managers hit an idle subordinate in the same cycle
    cur_test = "priority";
    for (int k = 0; k < 2; k++) begin
      wait_drain();
      base = {rand_bits(AW - 3), 3'b000} | AW'(k);
      for (int n = 0; n < 3; n++) begin
        load_addr[n] = base + AW'(n * 2);
        load_req[n] = 1'b1;
      end
      prio_arm[k] = 1'b1;
      wait_drain();
      if (prio_arm[k]) begin
        report_error($sformatf("subordinate %0d never forwarded an address", k));
      end
    end
    finish_test();

    cur_test = "random";
    for (int n = 0; n < 3; n++) begin
      budget[n] = N_RAND;
    end
    wait_drain();
    finish_test();

    // Back-to-back reads against slow subordinates
    cur_test = "stress";
    stress = 1'b1;
    max_out[0] = 0;
    max_out[1] = 0;
    for (int n = 0; n < 3; n++) begin
      budget[n] = N_STRESS;
    end
    wait_drain();
    check_value("stress s0 pipelined", 1, max_out[0] > 1);
    check_value("stress s1 pipelined", 1, max_out[1] > 1);
    finish_test();

    cur_test = "completion";
    check_value("completion completed", TOTAL_READS, completed);
    finish_test();

    $display("Tests run %0d, errors %0d", tests_run, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
hw/axi_xbar_pkg.sv
hw/grant_arbiter.sv
hw/grant_fifo.sv
hw/rd_sub_port.sv
hw/axi_rd_3to2.sv
test/tb_axi_rd_3to2.sv
